/* source/async_fifo_pkg.sv */
//--------------------------------------------------------------------
// Shared widths and types for the dual-clock FIFO
// ADDRSIZE must be 2 or more because the full compare inverts two
// pointer bits. Depth is always a power of two (1 << ADDRSIZE)
//--------------------------------------------------------------------

package async_fifo_pkg;

    // Width of one stored word
    parameter int unsigned DATASIZE = 8;

    // Memory address bits, giving 16 entries
    parameter int unsigned ADDRSIZE = 4;

    // One data word as stored in the memory
    typedef logic [DATASIZE-1:0] data_t;

    // Memory address without the wrap bit
    typedef logic [ADDRSIZE-1:0] addr_t;

    // Binary or Gray pointer with one extra wrap bit on top
    // The wrap bit tells a full FIFO apart from an empty one
    typedef logic [ADDRSIZE:0] ptr_t;

    //--------------------------------------------------------------------
    // Memory port bundles
    //--------------------------------------------------------------------

    // Write command from the write side, 13 bits wide
    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } mem_wr_t;

    // Read address from the read side
    typedef struct packed {
        addr_t addr;
    } mem_rd_t;

endpackage

/* source/fifo_mem_dp.sv */
//--------------------------------------------------------------------
// Storage array for the FIFO, one write port and one read port
// Writes land on the a_clk edge while mem_wr.en is high
// The read port is combinational so the head word falls through
// Contents are undefined after reset until written
//--------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_mem_dp (
    input  logic                    a_clk,
    input  async_fifo_pkg::mem_wr_t mem_wr,
    input  async_fifo_pkg::mem_rd_t mem_rd,
    output async_fifo_pkg::data_t   rdata
);

    import async_fifo_pkg::*;

    // Number of entries follows from the address width
    localparam int unsigned DEPTH = 1 << ADDRSIZE;

    // The storage itself
    data_t mem [DEPTH];

    //--------------------------------------------------------------------
    // Write port in the a_clk domain
    //--------------------------------------------------------------------

    // The write side only raises en for an accepted word
    // so no further qualification is done here
    always_ff @(posedge a_clk) begin
        if (mem_wr.en) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    //--------------------------------------------------------------------
    // Read port for the b_clk domain
    //--------------------------------------------------------------------

    // Asynchronous read of the head entry
    // The read side only points here at entries the write side has
    // already released through the synchronized Gray pointer, so the
    // word is stable by the time b_clk logic samples it
    assign rdata = mem[mem_rd.addr];

endmodule

/* source/gray_ptr_sync.sv */
//--------------------------------------------------------------------
// Two-flop synchronizer for a Gray pointer
// Only safe while the source moves by at most one bit per edge
// Output lags the source by two destination clock edges
//--------------------------------------------------------------------

`timescale 1ns/1ps

module gray_ptr_sync (
    input  logic                 clk_dst,
    input  logic                 rst_n,
    input  async_fifo_pkg::ptr_t gray_in,
    output async_fifo_pkg::ptr_t gray_out
);

    import async_fifo_pkg::*;

    // First stage may go metastable and is never used directly
    ptr_t gray_meta;

    // Both stages clear with the shared reset, so each side starts
    // from a zero view of the other pointer
    always_ff @(posedge clk_dst or negedge rst_n) begin
        if (!rst_n) begin
            gray_meta <= '0;
            gray_out  <= '0;
        end else begin
            // Capture from the foreign domain
            gray_meta <= gray_in;
            // Second stage gives the first one a full cycle to settle
            gray_out  <= gray_meta;
        end
    end

endmodule

/* source/wr_ptr_full.sv */
//--------------------------------------------------------------------
// Write side of the FIFO, running on a_clk
// A word is taken when winc is high and wfull is low
// wfull is registered and may stay high a few cycles after a read
// because the read pointer arrives through a synchronizer
//--------------------------------------------------------------------

`timescale 1ns/1ps

module wr_ptr_full (
    input  logic                    a_clk,
    input  logic                    rst_n,
    input  async_fifo_pkg::data_t   wdata,
    input  logic                    winc,
    input  async_fifo_pkg::ptr_t    rgray_sync,
    output async_fifo_pkg::ptr_t    wgray,
    output logic                    wfull,
    output async_fifo_pkg::mem_wr_t mem_wr
);

    import async_fifo_pkg::*;

    // Binary pointer addresses the memory, Gray copy crosses domains
    ptr_t wbin;
    ptr_t wbin_next;
    ptr_t wgray_next;
    // Read pointer as it looks when the FIFO is full
    ptr_t rgray_full;
    logic wr_accept;
    logic wfull_next;

    //--------------------------------------------------------------------
    // Next pointer and full detection
    //--------------------------------------------------------------------

    // Writes while full are dropped here
    assign wr_accept  = winc & ~wfull;
    assign wbin_next  = wbin + ptr_t'(wr_accept);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    // Full means the write pointer is one lap ahead of the read pointer
    // In Gray code that is the read pointer with its two top bits flipped
    assign rgray_full = {~rgray_sync[ADDRSIZE:ADDRSIZE-1], rgray_sync[ADDRSIZE-2:0]};
    assign wfull_next = (wgray_next == rgray_full);

    //--------------------------------------------------------------------
    // Pointer and flag registers
    //--------------------------------------------------------------------

    always_ff @(posedge a_clk or negedge rst_n) begin
        if (!rst_n) begin
            wbin  <= '0;
            wgray <= '0;
            wfull <= 1'b0;
        end else begin
            wbin  <= wbin_next;
            // Registered Gray copy only ever changes one bit per edge
            wgray <= wgray_next;
            // Set on the edge that takes the last free entry
            wfull <= wfull_next;
        end
    end

    // Memory write command for the current slot
    always_comb begin
        mem_wr.en   = wr_accept;
        mem_wr.addr = wbin[ADDRSIZE-1:0];
        mem_wr.data = wdata;
    end

endmodule

/* source/rd_ptr_empty.sv */
//--------------------------------------------------------------------
// Read side of the FIFO, running on b_clk
// The head is popped when rinc is high and rempty is low
// rempty is registered and resets high; it may stay high a few
// cycles after a write because of the pointer synchronizer
//--------------------------------------------------------------------

`timescale 1ns/1ps

module rd_ptr_empty (
    input  logic                    b_clk,
    input  logic                    rst_n,
    input  logic                    rinc,
    input  async_fifo_pkg::ptr_t    wgray_sync,
    output async_fifo_pkg::ptr_t    rgray,
    output logic                    rempty,
    output async_fifo_pkg::mem_rd_t mem_rd
);

    import async_fifo_pkg::*;

    // Binary pointer addresses the memory, Gray copy crosses domains
    ptr_t rbin;
    ptr_t rbin_next;
    ptr_t rgray_next;
    logic rd_accept;
    logic rempty_next;

    //--------------------------------------------------------------------
    // Next pointer and empty detection
    //--------------------------------------------------------------------

    // Reads while empty do nothing
    assign rd_accept  = rinc & ~rempty;
    assign rbin_next  = rbin + ptr_t'(rd_accept);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // Empty when the read pointer catches the write pointer exactly,
    // wrap bit included
    assign rempty_next = (rgray_next == wgray_sync);

    //--------------------------------------------------------------------
    // Pointer and flag registers
    //--------------------------------------------------------------------

    always_ff @(posedge b_clk or negedge rst_n) begin
        if (!rst_n) begin
            rbin   <= '0;
            rgray  <= '0;
            // Nothing to read after reset
            rempty <= 1'b1;
        end else begin
            rbin   <= rbin_next;
            // Gray copy goes to the write side synchronizer
            rgray  <= rgray_next;
            // Set on the edge of the pop that empties the FIFO
            rempty <= rempty_next;
        end
    end

    // The head address comes straight from the register
    // so rdata shows the oldest word without a pop
    always_comb begin
        mem_rd.addr = rbin[ADDRSIZE-1:0];
    end

endmodule

/* source/async_fifo.sv */
//--------------------------------------------------------------------
// Dual-clock FIFO, written on a_clk and read on b_clk
// One asynchronous rst_n clears both domains and must be released
// cleanly with respect to both clocks by the system
// Read data falls through and is valid whenever rempty is low
//--------------------------------------------------------------------

`timescale 1ns/1ps

module async_fifo (
    input  logic                  a_clk,
    input  logic                  b_clk,
    input  logic                  rst_n,
    input  async_fifo_pkg::data_t wdata,
    input  logic                  winc,
    output logic                  wfull,
    output async_fifo_pkg::data_t rdata,
    input  logic                  rinc,
    output logic                  rempty
);

    import async_fifo_pkg::*;

    // Memory ports
    mem_wr_t mem_wr;
    mem_rd_t mem_rd;

    // Gray pointers at the source and after crossing
    ptr_t wgray;
    ptr_t rgray;
    ptr_t wgray_sync;
    ptr_t rgray_sync;

    //--------------------------------------------------------------------
    // Write side in a_clk
    //--------------------------------------------------------------------

    wr_ptr_full i_wr_ptr_full (
        .a_clk      (a_clk),
        .rst_n      (rst_n),
        .wdata      (wdata),
        .winc       (winc),
        .rgray_sync (rgray_sync),
        .wgray      (wgray),
        .wfull      (wfull),
        .mem_wr     (mem_wr)
    );

    // Storage shared by both domains
    fifo_mem_dp i_mem (
        .a_clk  (a_clk),
        .mem_wr (mem_wr),
        .mem_rd (mem_rd),
        .rdata  (rdata)
    );

    // Write pointer into the read domain
    gray_ptr_sync i_sync_w2r (
        .clk_dst  (b_clk),
        .rst_n    (rst_n),
        .gray_in  (wgray),
        .gray_out (wgray_sync)
    );

    // Read pointer into the write domain
    gray_ptr_sync i_sync_r2w (
        .clk_dst  (a_clk),
        .rst_n    (rst_n),
        .gray_in  (rgray),
        .gray_out (rgray_sync)
    );

    //--------------------------------------------------------------------
    // Read side in b_clk
    //--------------------------------------------------------------------

    rd_ptr_empty i_rd_ptr_empty (
        .b_clk      (b_clk),
        .rst_n      (rst_n),
        .rinc       (rinc),
        .wgray_sync (wgray_sync),
        .rgray      (rgray),
        .rempty     (rempty),
        .mem_rd     (mem_rd)
    );

endmodule

/* test/async_fifo_properties.sv */
//--------------------------------------------------------------------
// Protocol assertions for the dual-clock FIFO, bound into async_fifo
// Sampled on each side's own clock; checks are off while rst_n is low
// The full and empty overlap check is sampled on a_clk only
//--------------------------------------------------------------------

`timescale 1ns/1ps

module async_fifo_properties (
    input logic                    a_clk,
    input logic                    b_clk,
    input logic                    rst_n,
    input async_fifo_pkg::ptr_t    wgray,
    input async_fifo_pkg::ptr_t    rgray,
    input logic                    wfull,
    input logic                    rempty,
    input async_fifo_pkg::mem_wr_t mem_wr
);

    import async_fifo_pkg::*;

    //--------------------------------------------------------------------
    // Gray pointer stepping
    //--------------------------------------------------------------------

    // A synchronizer can only carry the pointer safely if one bit moves per edge
    wgray_one_bit: assert property (@(posedge a_clk) disable iff (!rst_n)
        $countones(wgray ^ $past(wgray)) <= 1)
        else $error("Write Gray pointer changed more than one bit in one a_clk cycle");

    rgray_one_bit: assert property (@(posedge b_clk) disable iff (!rst_n)
        $countones(rgray ^ $past(rgray)) <= 1)
        else $error("Read Gray pointer changed more than one bit in one b_clk cycle");

    //--------------------------------------------------------------------
    // Flags
    //--------------------------------------------------------------------

    // With 16 entries and these clock rates the read side cannot still
    // see empty once the write side has filled every slot
    flags_exclusive: assert property (@(posedge a_clk) disable iff (!rst_n)
        !(wfull && rempty))
        else $error("wfull and rempty are both high");

    // The write side must drop any winc that arrives while full
    no_write_when_full: assert property (@(posedge a_clk) disable iff (!rst_n)
        !(mem_wr.en && wfull))
        else $error("Memory write enable is high while wfull is high");

endmodule

// Attach to every async_fifo instance, internal pointers included
bind async_fifo async_fifo_properties i_props (
    .a_clk  (a_clk),
    .b_clk  (b_clk),
    .rst_n  (rst_n),
    .wgray  (wgray),
    .rgray  (rgray),
    .wfull  (wfull),
    .rempty (rempty),
    .mem_wr (mem_wr)
);

/* test/async_fifo_tb.sv */
//--------------------------------------------------------------------
// Testbench for the dual-clock FIFO
// a_clk is 8 ns and b_clk 11 ns, so rising edges never coincide
// Producer and consumer are throttled by xorshift generators
// The first failing check prints a message and stops the run
//--------------------------------------------------------------------

`timescale 1ns/1ps

module async_fifo_tb;

    import async_fifo_pkg::*;

    localparam int FIFO_DEPTH    = 16;
    localparam int RANDOM_WORDS  = 200;
    localparam int COND_WFULL    = 0;
    localparam int COND_NONEMPTY = 1;
    localparam int COND_WR_DONE  = 2;
    localparam int COND_DRAINED  = 3;

    // DUT ports, all inputs start at a defined value
    logic  a_clk  = 1'b0;
    logic  b_clk  = 1'b0;
    logic  rst_n  = 1'b0;
    data_t wdata  = '0;
    logic  winc   = 1'b0;
    logic  rinc   = 1'b0;
    logic  wfull;
    logic  rempty;
    data_t rdata;

    // Scoreboard of words accepted but not yet popped, oldest first
    data_t sb[$];

    // Traffic control, set by the main sequence
    logic [2:0] wr_rate    = 3'd0;
    logic [2:0] rd_rate    = 3'd0;
    int         wr_target  = 0;
    logic       fill_check = 1'b0;
    int         fill_base  = 0;
    logic       rand_phase = 1'b0;
    int         rd_base    = 0;

    // Owned by the producer and consumer blocks
    int          wr_offered = 0;
    int          wr_count   = 0;
    int          rd_count   = 0;
    logic [31:0] wr_state   = 32'd5184;
    logic [31:0] rd_state   = 32'd5184;
    logic        seen_full  = 1'b0;
    logic        seen_empty = 1'b0;

    always #4 a_clk = ~a_clk;
    always #5.5 b_clk = ~b_clk;

    async_fifo i_dut (
        .a_clk  (a_clk),
        .b_clk  (b_clk),
        .rst_n  (rst_n),
        .wdata  (wdata),
        .winc   (winc),
        .wfull  (wfull),
        .rdata  (rdata),
        .rinc   (rinc),
        .rempty (rempty)
    );

    //--------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic condition_holds(input int what);
        case (what)
            COND_WFULL:    return wfull === 1'b1;
            COND_NONEMPTY: return rempty === 1'b0;
            COND_WR_DONE:  return (wr_offered == wr_target) && !winc;
            default:       return (wr_offered == wr_target) && !winc &&
                                  (sb.size() == 0) && (rempty === 1'b1);
        endcase
    endfunction

    // Polls on the falling a_clk edge, away from every DUT update
    task automatic poll_until(input int what, input int limit, input string stall_text);
        int n;
        n = 0;
        do begin
            @(negedge a_clk);
            n++;
        end while (!condition_holds(what) && n < limit);
        if (!condition_holds(what)) begin
            report_failure($sformatf("Timeout after %0d a_clk cycles: %s", limit, stall_text));
        end
    endtask

    task automatic wait_a_cycles(input int n);
        repeat (n) @(negedge a_clk);
    endtask

    //--------------------------------------------------------------------
    // Producer in a_clk, holds an offered word until it is taken
    //--------------------------------------------------------------------

    always @(posedge a_clk) begin
        if (rst_n) begin
            wr_state = xorshift32(wr_state);
            // With reads off, full follows exactly from the accepted count
            if (fill_check) begin
                assert (wfull === ((wr_count - fill_base) >= FIFO_DEPTH))
                    else report_failure($sformatf("FAIL wfull expected %h got %h",
                        ((wr_count - fill_base) >= FIFO_DEPTH), wfull));
            end
            if (rand_phase && wfull) seen_full = 1'b1;
            if (winc && !wfull) begin
                sb.push_back(wdata);
                wr_count++;
            end
            // A new word only once the slot is free
            if (!winc || !wfull) begin
                if (wr_offered < wr_target && {1'b0, wr_state[1:0]} < wr_rate) begin
                    winc  <= 1'b1;
                    wdata <= wr_state[15:8];
                    wr_offered++;
                end else begin
                    winc <= 1'b0;
                end
            end
        end
    end

    //--------------------------------------------------------------------
    // Consumer in b_clk with the data checks
    //--------------------------------------------------------------------

    always @(posedge b_clk) begin
        if (rst_n) begin
            rd_state = xorshift32(rd_state);
            if (!rempty) begin
                assert (sb.size() > 0)
                    else report_failure("FIFO shows data while no word is outstanding");
                // Head word must already be visible before any pop
                assert (rdata === sb[0])
                    else report_failure($sformatf("FAIL rdata expected %h got %h",
                        sb[0], rdata));
                if (rinc) begin
                    void'(sb.pop_front());
                    rd_count++;
                end
            end
            if (rand_phase && rempty && rd_count > rd_base) seen_empty = 1'b1;
            rinc <= ({1'b0, rd_state[1:0]} < rd_rate);
        end
    end

    // Flags may only rise on the edge that took a word or popped one
    assert property (@(posedge a_clk) disable iff (!rst_n) $rose(wfull) |-> $past(winc))
        else report_failure("wfull rose although no write was presented");

    // The step of rempty to its reset value is not a rise
    assert property (@(posedge b_clk) disable iff (!rst_n)
        ($rose(rempty) && $past(rst_n)) |-> $past(rinc))
        else report_failure("rempty rose although no read was presented");

    //--------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------

    initial begin
        repeat (2) @(posedge a_clk);
        rst_n <= 1'b1;

        // Reset state, then pop attempts on an empty FIFO
        @(negedge a_clk);
        assert (rempty === 1'b1)
            else report_failure($sformatf("FAIL rempty expected %h got %h", 1'b1, rempty));
        assert (wfull === 1'b0)
            else report_failure($sformatf("FAIL wfull expected %h got %h", 1'b0, wfull));
        rd_rate <= 3'd4;
        wait_a_cycles(4);
        rd_rate <= 3'd0;
        wait_a_cycles(4);
        assert (rempty === 1'b1)
            else report_failure($sformatf("FAIL rempty expected %h got %h", 1'b1, rempty));
        wr_rate   <= 3'd4;
        wr_target <= wr_target + 1;
        poll_until(COND_NONEMPTY, 100, "rempty never fell after the first write");
        rd_rate <= 3'd4;
        poll_until(COND_DRAINED, 200, "the first word was never read back");
        rd_rate <= 3'd0;
        wait_a_cycles(4);

        // Fill with reads off; one extra word waits while full
        fill_base  <= wr_count;
        fill_check <= 1'b1;
        wr_target  <= wr_target + FIFO_DEPTH + 1;
        poll_until(COND_WFULL, 200, "wfull never rose while filling");
        wait_a_cycles(6);
        assert (wr_count - fill_base == FIFO_DEPTH)
            else report_failure($sformatf("FAIL accepted_words expected %h got %h",
                FIFO_DEPTH, wr_count - fill_base));
        assert (winc === 1'b1) else report_failure("Held word was taken while full");
        fill_check <= 1'b0;
        rd_rate    <= 3'd4;
        poll_until(COND_DRAINED, 500, "FIFO did not drain after the fill");

        // Random traffic, first pushing toward full and then toward empty
        rd_base    <= rd_count;
        rand_phase <= 1'b1;
        wr_rate    <= 3'd3;
        rd_rate    <= 3'd1;
        wr_target  <= wr_target + RANDOM_WORDS;
        poll_until(COND_WR_DONE, 10000, "fast writer stalled");
        wr_rate    <= 3'd1;
        rd_rate    <= 3'd3;
        wr_target  <= wr_target + RANDOM_WORDS;
        poll_until(COND_WR_DONE, 10000, "slow writer stalled");
        rd_rate    <= 3'd4;
        poll_until(COND_DRAINED, 1000, "FIFO did not drain after random traffic");
        rand_phase <= 1'b0;
        wait_a_cycles(2);
        assert (seen_full) else report_failure("Random traffic never filled the FIFO");
        assert (seen_empty) else report_failure("Random traffic never emptied the FIFO");

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* build.f */
source/async_fifo_pkg.sv
source/fifo_mem_dp.sv
source/gray_ptr_sync.sv
source/wr_ptr_full.sv
source/rd_ptr_empty.sv
source/async_fifo.sv
test/async_fifo_properties.sv
test/async_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the FIFO testbench with Verilator and run it
# The simulator exits non-zero on any failed check
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module async_fifo_tb \
    -Mdir obj_dir \
    -f build.f

./obj_dir/Vasync_fifo_tb
